// File: rtl/ddr_ctrl_pkg.sv
package ddr_ctrl_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 26;
  localparam int DM_W = DATA_W / 8; // one mask bit per byte lane

  typedef enum logic [2:0] {
    CMD_NOP = 3'd0,
    CMD_SCR = 3'd1,
    CMD_SCW = 3'd2,
    CMD_BLR = 3'd3,  // recognized, then dropped
    CMD_BLW = 3'd4,  // recognized, then dropped
    CMD_ATR = 3'd5,
    CMD_ATW = 3'd6
  } ddr_cmd_code_t;

  typedef enum logic [2:0] {
    ALU_NOT  = 3'd0,
    ALU_NAND = 3'd1,
    ALU_NOR  = 3'd2,
    ALU_XOR  = 3'd3,
    ALU_ADD  = 3'd4,
    ALU_FLIP = 3'd5,
    ALU_SRA  = 3'd6,
    ALU_SLA  = 3'd7
  } ddr_alu_op_t;

  typedef struct packed {
    ddr_cmd_code_t     cmd;
    logic [ADDR_W-1:0] addr; // bank 25:23, row 22:10, col 9:0
    ddr_alu_op_t       op;
  } ddr_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ddr_ret_t;

  typedef struct packed {
    logic        cs_n;
    logic        ras_n;
    logic        cas_n;
    logic        we_n;
    logic [2:0]  ba;
    logic [13:0] a;
  } ddr_cmd_bus_t;

  typedef struct packed {
    logic wr_load;
    logic rd_capture;
    logic alu_load;
    logic burst_on;
    logic beat_unmask;
    logic dqs_toggle;
  } ddr_dp_ctrl_t;

  // {cs_n, ras_n, cas_n, we_n}
  localparam logic [3:0] DRAM_NOP   = 4'b0111;
  localparam logic [3:0] DRAM_ACT   = 4'b0011;
  localparam logic [3:0] DRAM_READ  = 4'b0101;
  localparam logic [3:0] DRAM_WRITE = 4'b0100;
  localparam logic [3:0] DRAM_PRE   = 4'b0010;
  localparam logic [3:0] DRAM_REF   = 4'b0001;

endpackage

// File: rtl/ddr_atomic_alu.sv
module ddr_atomic_alu (
  input  logic [ddr_ctrl_pkg::DATA_W-1:0] op_a, // old memory word
  input  logic [ddr_ctrl_pkg::DATA_W-1:0] op_b, // fifo operand
  input  ddr_ctrl_pkg::ddr_alu_op_t       op,
  output logic [ddr_ctrl_pkg::DATA_W-1:0] result
);

  always_comb
  begin
    result = '0;
    case (op)
      ddr_ctrl_pkg::ALU_NOT:  result = ~op_a;
      ddr_ctrl_pkg::ALU_NAND: result = ~(op_a & op_b);
      ddr_ctrl_pkg::ALU_NOR:  result = ~(op_a | op_b);
      ddr_ctrl_pkg::ALU_XOR:  result = op_a ^ op_b;
      ddr_ctrl_pkg::ALU_ADD:  result = op_a + op_b; // wraps mod 2^16
      ddr_ctrl_pkg::ALU_FLIP:
      begin
        for (int i = 0; i < ddr_ctrl_pkg::DATA_W; i++)
        begin
          result[i] = op_a[ddr_ctrl_pkg::DATA_W-1-i];
        end
      end
      ddr_ctrl_pkg::ALU_SRA:
      begin
        result = {op_a[ddr_ctrl_pkg::DATA_W-1], op_a[ddr_ctrl_pkg::DATA_W-1:1]};
      end
      ddr_ctrl_pkg::ALU_SLA:
      begin
        result = {op_a[ddr_ctrl_pkg::DATA_W-2:0], 1'b0};
      end
      default: result = '0;
    endcase
  end

endmodule

// File: rtl/ddr_refresh_timer.sv
module ddr_refresh_timer #(
  parameter int REFRESH_INTERVAL = 4800
) (
  input  logic clk,
  input  logic reset,
  input  logic refresh_done,
  output logic refresh_due
);

  localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);
  localparam logic [CNT_W-1:0] DUE_AT = CNT_W'(REFRESH_INTERVAL - 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (reset || refresh_done)
    begin
      count <= '0;
      refresh_due <= 1'b0;
    end
    else if (!refresh_due) // hold once due
    begin
      count <= count + 1'b1;
      if (count == DUE_AT)
        refresh_due <= 1'b1;
    end
  end

endmodule

// File: rtl/ddr_cmd_sequencer.sv
module ddr_cmd_sequencer #(
  parameter int T_RCD      = 10,
  parameter int READ_LAT   = 16,
  parameter int WRITE_LAT  = 16,
  parameter int RD_WR_GAP  = 22,
  parameter int WR_RECOVER = 20,
  parameter int T_RFC      = 68
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cmd_empty,
  input  ddr_ctrl_pkg::ddr_req_t              cmd_req,
  output logic                                cmd_get,
  output logic                                data_get,
  input  logic                                ret_full,
  output logic                                ret_put,
  output logic [ddr_ctrl_pkg::ADDR_W-1:0]     ret_addr,
  input  logic                                refresh_due,
  output logic                                refresh_done,
  output ddr_ctrl_pkg::ddr_cmd_bus_t          ddr_cmd,
  output ddr_ctrl_pkg::ddr_dp_ctrl_t          dp_ctrl,
  output ddr_ctrl_pkg::ddr_alu_op_t           alu_op
);

  localparam int CNT_MAX = T_RCD + READ_LAT + RD_WR_GAP + WRITE_LAT + WR_RECOVER + T_RFC;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  // counts are relative to accept, READ/WRITE or PRE
  localparam logic [CNT_W-1:0] C_RW_ISSUE  = CNT_W'(T_RCD);
  localparam logic [CNT_W-1:0] C_RD_BEAT   = CNT_W'(READ_LAT - 1);
  localparam logic [CNT_W-1:0] C_RET       = CNT_W'(READ_LAT + 4);
  localparam logic [CNT_W-1:0] C_RD_DONE   = CNT_W'(READ_LAT + 5);
  localparam logic [CNT_W-1:0] C_ATW_ISSUE = CNT_W'(RD_WR_GAP - 1);
  localparam logic [CNT_W-1:0] C_OE_ON     = CNT_W'(WRITE_LAT - 2);
  localparam logic [CNT_W-1:0] C_DQS_OFF   = CNT_W'(WRITE_LAT + 2);
  localparam logic [CNT_W-1:0] C_OE_OFF    = CNT_W'(WRITE_LAT + 3);
  localparam logic [CNT_W-1:0] C_WR_BEAT   = CNT_W'(WRITE_LAT - 1);
  localparam logic [CNT_W-1:0] C_WR_DONE   = CNT_W'(WRITE_LAT + WR_RECOVER - 1);
  localparam logic [CNT_W-1:0] C_REF       = CNT_W'(1);
  localparam logic [CNT_W-1:0] C_RFC_DONE  = CNT_W'(T_RFC + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACCEPT,
    ST_ACTIVATE,
    ST_READ,
    ST_WRITE,
    ST_ATOMIC,
    ST_REFRESH
  } state_t;

  state_t                 state;
  logic [CNT_W-1:0]       cnt;
  ddr_ctrl_pkg::ddr_req_t req_q;
  logic [2:0]             bank;
  logic [9:0]             col;
  logic [CNT_W-1:0]       beat_ext;
  logic                   code_valid;
  logic                   needs_data;
  logic                   wr_phase;
  logic                   rd_phase;

  assign bank = req_q.addr[25:23];
  assign col = req_q.addr[9:0];
  assign beat_ext = {{(CNT_W-2){1'b0}}, col[1:0]};
  assign ret_addr = req_q.addr;
  assign alu_op = req_q.op;

  assign cmd_get = (state == ST_ACCEPT) && !cmd_empty && !ret_full;
  assign refresh_done = (state == ST_REFRESH) && (cnt == C_RFC_DONE);

  assign code_valid = cmd_req.cmd inside {ddr_ctrl_pkg::CMD_SCR, ddr_ctrl_pkg::CMD_SCW,
                                          ddr_ctrl_pkg::CMD_ATR, ddr_ctrl_pkg::CMD_ATW};
  assign needs_data = cmd_req.cmd inside {ddr_ctrl_pkg::CMD_SCW, ddr_ctrl_pkg::CMD_ATR,
                                          ddr_ctrl_pkg::CMD_ATW};

  assign wr_phase = (state == ST_WRITE);
  assign rd_phase = (state == ST_READ) || (state == ST_ATOMIC);

  always_ff @(posedge clk)
  begin
    if (cmd_get)
      req_q <= cmd_req;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      cnt <= '0;
      ddr_cmd <= '{cs_n: 1'b0, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1, ba: '0, a: '0};
      data_get <= 1'b0;
      ret_put <= 1'b0;
      dp_ctrl <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;
      {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <= ddr_ctrl_pkg::DRAM_NOP;
      data_get <= 1'b0;
      ret_put <= 1'b0;
      dp_ctrl.wr_load <= 1'b0;
      dp_ctrl.alu_load <= 1'b0;
      dp_ctrl.rd_capture <= rd_phase && (cnt == C_RD_BEAT + beat_ext);
      dp_ctrl.beat_unmask <= wr_phase && (cnt == C_WR_BEAT + beat_ext);
      dp_ctrl.burst_on <= wr_phase && (cnt >= C_OE_ON) && (cnt <= C_OE_OFF);
      dp_ctrl.dqs_toggle <= wr_phase && (cnt >= C_OE_ON) && (cnt <= C_DQS_OFF);
      case (state)
        ST_IDLE:
        begin
          cnt <= '0;
          if (refresh_due) // precharge all first
          begin
            {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <= ddr_ctrl_pkg::DRAM_PRE;
            ddr_cmd.a <= {3'b000, 1'b1, 10'd0};
            state <= ST_REFRESH;
          end
          else if (!cmd_empty && !ret_full)
            state <= ST_ACCEPT;
        end
        ST_ACCEPT:
        begin
          state <= ST_IDLE;
          if (cmd_get && code_valid)
          begin
            {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <= ddr_ctrl_pkg::DRAM_ACT;
            ddr_cmd.ba <= cmd_req.addr[25:23];
            ddr_cmd.a <= {1'b0, cmd_req.addr[22:10]};
            data_get <= needs_data;
            dp_ctrl.wr_load <= needs_data;
            cnt <= CNT_W'(1);
            state <= ST_ACTIVATE;
          end
        end
        ST_ACTIVATE:
        begin
          if (cnt == C_RW_ISSUE)
          begin
            cnt <= '0;
            ddr_cmd.ba <= bank;
            if (req_q.cmd == ddr_ctrl_pkg::CMD_SCW)
            begin
              {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <=
                ddr_ctrl_pkg::DRAM_WRITE;
              ddr_cmd.a <= {3'b000, 1'b1, col};
              state <= ST_WRITE;
            end
            else
            begin
              {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <=
                ddr_ctrl_pkg::DRAM_READ;
              if (req_q.cmd == ddr_ctrl_pkg::CMD_SCR)
              begin
                ddr_cmd.a <= {3'b000, 1'b1, col};
                state <= ST_READ;
              end
              else
              begin
                ddr_cmd.a <= {3'b000, 1'b0, col}; // row stays open for the write back
                state <= ST_ATOMIC;
              end
            end
          end
        end
        ST_READ:
        begin
          if (cnt == C_RET)
            ret_put <= 1'b1;
          if (cnt == C_RD_DONE)
            state <= ST_IDLE;
        end
        ST_ATOMIC:
        begin
          if (cnt == C_RET)
          begin
            dp_ctrl.alu_load <= 1'b1;
            ret_put <= (req_q.cmd == ddr_ctrl_pkg::CMD_ATR); // old word back
          end
          if (cnt == C_ATW_ISSUE)
          begin
            {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <= ddr_ctrl_pkg::DRAM_WRITE;
            ddr_cmd.a <= {3'b000, 1'b1, col};
            cnt <= '0;
            state <= ST_WRITE;
          end
        end
        ST_WRITE:
        begin
          if (cnt == C_WR_DONE)
            state <= ST_IDLE;
        end
        ST_REFRESH:
        begin
          if (cnt == C_REF)
            {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} <= ddr_ctrl_pkg::DRAM_REF;
          if (refresh_done)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/ddr_data_path.sv
module ddr_data_path (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [ddr_ctrl_pkg::DATA_W-1:0]     wr_data,
  input  ddr_ctrl_pkg::ddr_dp_ctrl_t          dp_ctrl,
  input  ddr_ctrl_pkg::ddr_alu_op_t           alu_op,
  input  logic [ddr_ctrl_pkg::DATA_W-1:0]     dq_in,
  output logic [ddr_ctrl_pkg::DATA_W-1:0]     rd_word,
  output logic [ddr_ctrl_pkg::DATA_W-1:0]     dq_out,
  output logic                                dq_oe,
  output logic [1:0]                          dqs_out,
  output logic [ddr_ctrl_pkg::DM_W-1:0]       dm
);

  logic [ddr_ctrl_pkg::DATA_W-1:0] wr_word;
  logic [ddr_ctrl_pkg::DATA_W-1:0] alu_result;

  ddr_atomic_alu i_alu (
    .op_a   (rd_word),
    .op_b   (wr_word),
    .op     (alu_op),
    .result (alu_result)
  );

  // operand from the data fifo, later the read-modify-write result
  always_ff @(posedge clk)
  begin
    if (dp_ctrl.wr_load)
      wr_word <= wr_data;
    else if (dp_ctrl.alu_load)
      wr_word <= alu_result;
  end

  always_ff @(posedge clk)
  begin
    if (dp_ctrl.rd_capture)
      rd_word <= dq_in; // selected beat only
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      dqs_out <= 2'b11;
    else if (dp_ctrl.dqs_toggle)
      dqs_out <= ~dqs_out;
    else
      dqs_out <= 2'b11; // preamble level
  end

  assign dq_out = wr_word;
  assign dq_oe = dp_ctrl.burst_on;
  assign dm = dp_ctrl.beat_unmask ? '0 : '1; // masked unless selected beat

endmodule

// File: rtl/ddr_ctrl_top.sv
module ddr_ctrl_top #(
  parameter int T_RCD            = 10,
  parameter int READ_LAT         = 16,
  parameter int WRITE_LAT        = 16,
  parameter int RD_WR_GAP        = 22,
  parameter int WR_RECOVER       = 20,
  parameter int T_RFC            = 68,
  parameter int REFRESH_INTERVAL = 4800
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cmd_empty,
  input  ddr_ctrl_pkg::ddr_req_t              cmd_req,
  output logic                                cmd_get,
  input  logic [ddr_ctrl_pkg::DATA_W-1:0]     wr_data,
  output logic                                data_get,
  input  logic                                ret_full,
  output logic                                ret_put,
  output ddr_ctrl_pkg::ddr_ret_t              ret,
  output ddr_ctrl_pkg::ddr_cmd_bus_t          ddr_cmd,
  input  logic [ddr_ctrl_pkg::DATA_W-1:0]     dq_in,
  output logic [ddr_ctrl_pkg::DATA_W-1:0]     dq_out,
  output logic                                dq_oe,
  output logic [1:0]                          dqs_out,
  output logic [ddr_ctrl_pkg::DM_W-1:0]       dm
);

  logic                       refresh_due;
  logic                       refresh_done;
  ddr_ctrl_pkg::ddr_dp_ctrl_t dp_ctrl;
  ddr_ctrl_pkg::ddr_alu_op_t  alu_op;

  ddr_refresh_timer #(
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) i_refresh_timer (
    .clk          (clk),
    .reset        (reset),
    .refresh_done (refresh_done),
    .refresh_due  (refresh_due)
  );

  ddr_cmd_sequencer #(
    .T_RCD      (T_RCD),
    .READ_LAT   (READ_LAT),
    .WRITE_LAT  (WRITE_LAT),
    .RD_WR_GAP  (RD_WR_GAP),
    .WR_RECOVER (WR_RECOVER),
    .T_RFC      (T_RFC)
  ) i_cmd_sequencer (
    .clk          (clk),
    .reset        (reset),
    .cmd_empty    (cmd_empty),
    .cmd_req      (cmd_req),
    .cmd_get      (cmd_get),
    .data_get     (data_get),
    .ret_full     (ret_full),
    .ret_put      (ret_put),
    .ret_addr     (ret.addr),
    .refresh_due  (refresh_due),
    .refresh_done (refresh_done),
    .ddr_cmd      (ddr_cmd),
    .dp_ctrl      (dp_ctrl),
    .alu_op       (alu_op)
  );

  ddr_data_path i_data_path (
    .clk     (clk),
    .reset   (reset),
    .wr_data (wr_data),
    .dp_ctrl (dp_ctrl),
    .alu_op  (alu_op),
    .dq_in   (dq_in),
    .rd_word (ret.data),
    .dq_out  (dq_out),
    .dq_oe   (dq_oe),
    .dqs_out (dqs_out),
    .dm      (dm)
  );

endmodule

// File: verif/ddr_dram_model.sv
module ddr_dram_model #(
  parameter int READ_LAT  = 16,
  parameter int WRITE_LAT = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  ddr_ctrl_pkg::ddr_cmd_bus_t ddr_cmd,
  input  logic [15:0]                dq_out,
  input  logic [1:0]                 dm,
  output logic [15:0]                dq_in
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] mem [logic [25:0]];
  logic [12:0] open_row [8];
  logic [3:0]  pins;
  logic [25:0] rd_base;
  logic [25:0] wr_base;
  int          rd_age;
  int          wr_age;

  function automatic logic [15:0] fill_word(input logic [25:0] key);
    return key[15:0] ^ {6'd0, key[25:16]} ^ 16'h5a5a;
  endfunction

  function automatic logic [15:0] read_word(input logic [25:0] key);
    return mem.exists(key) ? mem[key] : fill_word(key);
  endfunction

  assign pins = {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n};

  initial dq_in = '0;

  // age n at an edge means the edge closing cycle cmd+n
  always @(posedge clk)
  begin
    if (reset)
    begin
      rd_age = 0;
      wr_age = 0;
    end
    else
    begin
      if (rd_age > 0)
      begin
        if (rd_age >= READ_LAT - 1 && rd_age <= READ_LAT + 2)
          dq_in <= read_word(rd_base | 26'(rd_age - READ_LAT + 1));
        rd_age = (rd_age > READ_LAT + 2) ? 0 : rd_age + 1;
      end
      if (wr_age > 0)
      begin
        if (wr_age >= WRITE_LAT && wr_age <= WRITE_LAT + 3 && dm == 2'b00)
          mem[wr_base | 26'(wr_age - WRITE_LAT)] = dq_out; // unmasked beat only
        wr_age = (wr_age > WRITE_LAT + 3) ? 0 : wr_age + 1;
      end
      case (pins)
        ddr_ctrl_pkg::DRAM_ACT: open_row[ddr_cmd.ba] = ddr_cmd.a[12:0];
        ddr_ctrl_pkg::DRAM_READ:
        begin
          rd_base = {ddr_cmd.ba, open_row[ddr_cmd.ba], ddr_cmd.a[9:2], 2'b00};
          rd_age = 1;
        end
        ddr_ctrl_pkg::DRAM_WRITE:
        begin
          wr_base = {ddr_cmd.ba, open_row[ddr_cmd.ba], ddr_cmd.a[9:2], 2'b00};
          wr_age = 1;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: verif/ddr_ctrl_tb.sv
module ddr_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int READ_LAT = 16;
  localparam int WRITE_LAT = 16;
  localparam int T_RFC = 68;
  localparam int REF_INT = 400;

  logic                       clk;
  logic                       reset;
  logic                       cmd_empty;
  ddr_ctrl_pkg::ddr_req_t     cmd_req;
  logic                       cmd_get;
  logic [15:0]                wr_data;
  logic                       data_get;
  logic                       ret_full;
  logic                       ret_put;
  ddr_ctrl_pkg::ddr_ret_t     ret;
  ddr_ctrl_pkg::ddr_cmd_bus_t ddr_cmd;
  logic [15:0]                dq_in;
  logic [15:0]                dq_out;
  logic                       dq_oe;
  logic [1:0]                 dqs_out;
  logic [1:0]                 dm;

  ddr_ctrl_pkg::ddr_req_t cmd_q [$];
  logic [15:0]            data_q [$];
  ddr_ctrl_pkg::ddr_ret_t exp_q [$];
  logic [15:0]            exp_mem [logic [25:0]];
  ddr_ctrl_pkg::ddr_req_t req_drop;
  logic [15:0]            data_drop;
  ddr_ctrl_pkg::ddr_ret_t exp_ret;
  logic [31:0]            rng_state = 32'd46570;
  logic [3:0]             pins;
  logic [1:0]             exp_dm;
  logic [1:0]             exp_dqs;
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int last_read = 0;
  int last_ref = 0;
  int wr_age = 0;
  int wr_col = 0;
  int ref_age = 0;
  int act_count = 0;
  int refresh_count = 0;
  bit pre_seen = 0;

  ddr_ctrl_top #(.REFRESH_INTERVAL(REF_INT)) i_dut (.*);

  ddr_dram_model #(.READ_LAT(READ_LAT), .WRITE_LAT(WRITE_LAT)) i_dram (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [15:0] apply_op(input ddr_ctrl_pkg::ddr_alu_op_t op,
                                           input logic [15:0] a, input logic [15:0] b);
    logic [15:0] r;
    case (op)
      ddr_ctrl_pkg::ALU_NOT:  r = ~a;
      ddr_ctrl_pkg::ALU_NAND: r = ~(a & b);
      ddr_ctrl_pkg::ALU_NOR:  r = ~(a | b);
      ddr_ctrl_pkg::ALU_XOR:  r = a ^ b;
      ddr_ctrl_pkg::ALU_ADD:  r = a + b;
      ddr_ctrl_pkg::ALU_FLIP: r = {<<{a}};
      ddr_ctrl_pkg::ALU_SRA:  r = {a[15], a[15:1]};
      default:                r = {a[14:0], 1'b0};
    endcase
    return r;
  endfunction

  // fifo models, fall-through front word
  always @(posedge clk)
  begin
    if (cmd_get && cmd_q.size() > 0)
      req_drop = cmd_q.pop_front();
    if (data_get && data_q.size() > 0)
      data_drop = data_q.pop_front();
    cmd_empty <= (cmd_q.size() == 0);
    cmd_req <= (cmd_q.size() > 0) ? cmd_q[0] : '0;
    wr_data <= (data_q.size() > 0) ? data_q[0] : '0;
  end

  always @(posedge clk)
  begin
    cyc++;
    pins = {ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n};
    if (!reset)
    begin
      assert (!(cmd_get && (cmd_empty || ret_full))) checks++;
      else begin errors++; $display("cmd_get rose while the fifo was empty or ret full"); end
      if (cmd_get)
        wr_col = int'(cmd_req.addr[1:0]); // one request in flight
      if (wr_age > 0) // write burst timing
      begin
        if (wr_age == WRITE_LAT - 2)
          assert (dq_oe === 1'b0) checks++;
          else begin errors++; $display("error: dq_oe expected 0 got %h", dq_oe); end
        if (wr_age == WRITE_LAT - 1)
          assert (dq_oe === 1'b1) checks++;
          else begin errors++; $display("error: dq_oe expected 1 got %h", dq_oe); end
        if (wr_age >= WRITE_LAT && wr_age <= WRITE_LAT + 3)
        begin
          exp_dm = (wr_age - WRITE_LAT == wr_col) ? 2'b00 : 2'b11;
          assert (dm === exp_dm) checks++;
          else begin errors++; $display("error: dm expected %h got %h", exp_dm, dm); end
        end
        if (wr_age >= WRITE_LAT - 1 && wr_age <= WRITE_LAT + 4)
        begin
          exp_dqs = ((wr_age - WRITE_LAT + 1) % 2 == 0) ? 2'b11 : 2'b00;
          assert (dqs_out === exp_dqs) checks++;
          else begin
            errors++;
            $display("error: dqs_out expected %h got %h", exp_dqs, dqs_out);
          end
        end
        wr_age = (wr_age > WRITE_LAT + 3) ? 0 : wr_age + 1;
      end
      if (ref_age > 0)
        ref_age = (ref_age >= T_RFC) ? 0 : ref_age + 1;
      case (pins)
        ddr_ctrl_pkg::DRAM_ACT:
        begin
          act_count++;
          assert (ref_age == 0) checks++;
          else begin errors++; $display("ACT issued within T_RFC after REF"); end
        end
        ddr_ctrl_pkg::DRAM_READ: last_read = cyc;
        ddr_ctrl_pkg::DRAM_WRITE: wr_age = 1;
        ddr_ctrl_pkg::DRAM_PRE: pre_seen = ddr_cmd.a[10];
        ddr_ctrl_pkg::DRAM_REF:
        begin
          assert (pre_seen && cyc - last_ref <= REF_INT + T_RFC + 150) checks++;
          else begin errors++; $display("REF late or without precharge-all"); end
          pre_seen = 0;
          last_ref = cyc;
          ref_age = 1;
          refresh_count++;
        end
        default: ;
      endcase
      if (ret_put)
      begin
        assert (exp_q.size() > 0) checks++;
        else begin errors++; $display("return pushed with no request pending"); end
        if (exp_q.size() > 0)
        begin
          exp_ret = exp_q.pop_front();
          assert (ret === exp_ret) checks++;
          else begin
            errors++;
            $display("error: ret expected %h/%h got %h/%h", exp_ret.addr, exp_ret.data,
                     ret.addr, ret.data);
          end
          assert (cyc - last_read == READ_LAT + 5) checks++;
          else begin errors++; $display("return %0d cycles after READ", cyc - last_read); end
        end
      end
    end
  end

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic queue_request(input ddr_ctrl_pkg::ddr_cmd_code_t code, input logic [25:0] addr,
                               input ddr_ctrl_pkg::ddr_alu_op_t op, input logic [15:0] data,
                               input bit has_data);
    ddr_ctrl_pkg::ddr_req_t r;
    r.cmd = code;
    r.addr = addr;
    r.op = op;
    @(negedge clk);
    if (has_data)
      data_q.push_back(data);
    cmd_q.push_back(r);
  endtask

  task automatic expect_return(input logic [25:0] addr, input logic [15:0] data);
    ddr_ctrl_pkg::ddr_ret_t e;
    e.addr = addr;
    e.data = data;
    exp_q.push_back(e);
  endtask

  task automatic write_word(input logic [25:0] addr, input logic [15:0] data);
    queue_request(ddr_ctrl_pkg::CMD_SCW, addr, ddr_ctrl_pkg::ALU_NOT, data, 1);
    exp_mem[addr] = data;
  endtask

  task automatic read_word(input logic [25:0] addr);
    expect_return(addr, exp_mem[addr]);
    queue_request(ddr_ctrl_pkg::CMD_SCR, addr, ddr_ctrl_pkg::ALU_NOT, '0, 0);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((cmd_q.size() != 0 || exp_q.size() != 0) && n < 10000)
    begin
      n++;
      @(posedge clk);
    end
    if (cmd_q.size() != 0 || exp_q.size() != 0)
    begin
      errors++;
      $display("timeout waiting for queued requests to finish");
    end
    repeat (4) @(posedge clk); // a stray ACT follows the pop by one cycle
  endtask

  task automatic run_atomic(input ddr_ctrl_pkg::ddr_cmd_code_t code);
    logic [31:0] r;
    logic [25:0] addr;
    logic [15:0] operand;
    ddr_ctrl_pkg::ddr_alu_op_t op;
    for (int k = 0; k < 8; k++)
    begin
      op = ddr_ctrl_pkg::ddr_alu_op_t'(k[2:0]);
      r = next_rand();
      addr = r[25:0];
      r = next_rand();
      write_word(addr, r[15:0]);
      operand = r[31:16];
      if (code == ddr_ctrl_pkg::CMD_ATR)
        expect_return(addr, exp_mem[addr]);
      queue_request(code, addr, op, operand, 1);
      exp_mem[addr] = apply_op(op, exp_mem[addr], operand);
      read_word(addr);
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [25:0] addr;
    int acts;
    reset = 1'b1;
    cmd_empty = 1'b1;
    cmd_req = '0;
    wr_data = '0;
    ret_full = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    assert ({ddr_cmd.cs_n, ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} == ddr_ctrl_pkg::DRAM_NOP
            && !dq_oe && !ret_put && !cmd_get && !data_get && dm === 2'b11) checks++;
    else begin errors++; $display("outputs not idle after reset"); end

    for (int i = 0; i < 6; i++)
    begin
      r = next_rand();
      addr = r[25:0];
      r = next_rand();
      write_word(addr, r[15:0]);
      read_word(addr);
    end
    run_atomic(ddr_ctrl_pkg::CMD_ATR);
    run_atomic(ddr_ctrl_pkg::CMD_ATW);
    wait_drained();

    acts = act_count; // dropped codes must not open a row
    queue_request(ddr_ctrl_pkg::CMD_BLR, addr, ddr_ctrl_pkg::ALU_NOT, '0, 0);
    queue_request(ddr_ctrl_pkg::CMD_BLW, addr, ddr_ctrl_pkg::ALU_NOT, '0, 0);
    queue_request(ddr_ctrl_pkg::ddr_cmd_code_t'(3'd7), addr, ddr_ctrl_pkg::ALU_NOT, '0, 0);
    wait_drained();
    assert (act_count == acts) checks++;
    else begin errors++; $display("ACT issued for a dropped command code"); end

    @(posedge clk);
    ret_full <= 1'b1;
    read_word(addr);
    repeat (30) @(posedge clk);
    assert (cmd_q.size() == 1) checks++;
    else begin errors++; $display("request accepted while ret_full was high"); end
    @(posedge clk);
    ret_full <= 1'b0;
    wait_drained();

    assert (refresh_count >= 2) checks++;
    else begin errors++; $display("too few refresh sequences seen"); end
    finish_run();
  end

endmodule

// File: ddr_ctrl_top.f
rtl/ddr_ctrl_pkg.sv
rtl/ddr_atomic_alu.sv
rtl/ddr_refresh_timer.sv
rtl/ddr_cmd_sequencer.sv
rtl/ddr_data_path.sv
rtl/ddr_ctrl_top.sv
verif/ddr_dram_model.sv
verif/ddr_ctrl_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module ddr_ctrl_tb \
		-f ddr_ctrl_top.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
